//--- verilog/core_pkg.sv
// Core storage package
// Widths, counts and types shared by the register file contexts,
// the instruction cache RAMs and the storage top level

package core_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned RegDataW = 32;
  localparam int unsigned NumRegs  = 32;
  localparam int unsigned RegAddrW = $clog2(NumRegs);

  // Main context plus one alternate copy
  localparam int unsigned NrRegCtx = 2;

  typedef logic [RegAddrW-1:0] reg_addr_t;
  typedef logic [RegDataW-1:0] reg_data_t;

  typedef enum logic [$clog2(NrRegCtx)-1:0] {
    RegCtxMain = 1'b0,
    RegCtxAlt  = 1'b1
  } reg_ctx_e;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction cache RAMs
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned IcNumWays  = 2;
  localparam int unsigned IcNumLines = 64;
  localparam int unsigned IcIndexW   = $clog2(IcNumLines);

  // Valid bit sits in the top bit of the tag
  localparam int unsigned IcTagW     = 22;

  // Two 32-bit bus beats per line
  localparam int unsigned IcLineW    = 64;

  typedef logic [IcIndexW-1:0]  ic_index_t;
  typedef logic [IcTagW-1:0]    ic_tag_t;
  typedef logic [IcLineW-1:0]   ic_line_t;
  typedef logic [IcNumWays-1:0] ic_way_mask_t;

endpackage

//--- verilog/core_sleep_ctrl.sv
// Core sleep controller
// Registers the core busy level, merges it with the wake sources and
// gates the core clock with a latch-based clock gate

`timescale 1ns/100ps

module core_sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,

  // Forces the gate open for test
  input  logic test_en_i,

  input  logic core_busy_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  input  logic debug_req_i,

  output logic clk_core_o,
  output logic core_sleep_o
);

  logic busy_q;
  logic clock_en;
  logic clock_en_latch;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= core_busy_i;
    end
  end

  // Any wake source opens the clock in the same cycle
  assign clock_en     = busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~clock_en;

  ////////////////////////////////////////////////////////////////////////////
  // Clock gate
  ////////////////////////////////////////////////////////////////////////////

  // Transparent while clk_i is low, so only whole pulses pass
  always_latch begin
    if (!clk_i) begin
      clock_en_latch = clock_en | test_en_i;
    end
  end

  assign clk_core_o = clk_i & clock_en_latch;

endmodule

//--- verilog/register_file_ff.sv
// Flip-flop register file
// 31 stored words with two combinational read ports and one write port;
// x0 is not stored and always reads zero

`timescale 1ns/100ps

module register_file_ff import core_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  // Read port A
  input  reg_addr_t raddr_a_i,
  output reg_data_t rdata_a_o,

  // Read port B
  input  reg_addr_t raddr_b_i,
  output reg_data_t rdata_b_o,

  // Write port
  input  reg_addr_t waddr_i,
  input  reg_data_t wdata_i,
  input  logic      we_i
);

  // Word 0 is the hardwired zero register
  reg_data_t rf_words [NumRegs];

  assign rf_words[0] = '0;

  ////////////////////////////////////////////////////////////////////////////
  // Storage for x1 to x31
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 1; i < NumRegs; i++) begin : gen_words
    logic      word_we;
    reg_data_t word_q;

    // Write address decode
    assign word_we = we_i && (waddr_i == reg_addr_t'(i));

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        word_q <= '0;
      end else if (word_we) begin
        word_q <= wdata_i;
      end
    end

    assign rf_words[i] = word_q;
  end

  // Read muxes
  assign rdata_a_o = rf_words[raddr_a_i];
  assign rdata_b_o = rf_words[raddr_b_i];

endmodule

//--- verilog/register_file_ctx.sv
// Register file contexts
// One flip-flop register file per context; the context select steers
// the write enable and picks the read data for both ports

`timescale 1ns/100ps

module register_file_ctx import core_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  input  reg_ctx_e  ctx_sel_i,

  // Read ports
  input  reg_addr_t raddr_a_i,
  output reg_data_t rdata_a_o,
  input  reg_addr_t raddr_b_i,
  output reg_data_t rdata_b_o,

  // Write port
  input  reg_addr_t waddr_i,
  input  reg_data_t wdata_i,
  input  logic      we_i
);

  logic      we_ctx      [NrRegCtx];
  reg_data_t rdata_a_ctx [NrRegCtx];
  reg_data_t rdata_b_ctx [NrRegCtx];

  for (genvar r = 0; r < NrRegCtx; r++) begin : gen_ctx
    // Unselected contexts keep their contents
    assign we_ctx[r] = we_i && (ctx_sel_i == reg_ctx_e'(r));

    register_file_ff u_register_file (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .raddr_a_i(raddr_a_i),
      .rdata_a_o(rdata_a_ctx[r]),
      .raddr_b_i(raddr_b_i),
      .rdata_b_o(rdata_b_ctx[r]),
      .waddr_i  (waddr_i),
      .wdata_i  (wdata_i),
      .we_i     (we_ctx[r])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read selection
  ////////////////////////////////////////////////////////////////////////////

  assign rdata_a_o = rdata_a_ctx[ctx_sel_i];
  assign rdata_b_o = rdata_b_ctx[ctx_sel_i];

endmodule

//--- verilog/ic_ram_1p.sv
// Instruction cache single-port RAM
// One cache way of tags or lines, with a one-cycle registered read

`timescale 1ns/100ps

module ic_ram_1p import core_pkg::*; #(
  parameter type payload_t = ic_line_t
) (
  input  logic      clk_i,

  input  logic      req_i,
  input  logic      write_i,
  input  ic_index_t addr_i,
  input  payload_t  wdata_i,
  output payload_t  rdata_o
);

  payload_t mem_q [IcNumLines];

  // Read data holds until the next read request
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (write_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

//--- verilog/core_storage_top.sv
// Core storage top level
// Sleep controller with the core clock gate, register file contexts on
// the gated clock and per-way instruction cache tag and data RAMs

`timescale 1ns/100ps

module core_storage_top import core_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,

  // Enables the core clock gate for test
  input  logic         test_en_i,

  // Sleep control
  input  logic         core_busy_i,
  input  logic         irq_pending_i,
  input  logic         irq_nm_i,
  input  logic         debug_req_i,
  output logic         core_sleep_o,

  // Register file
  input  reg_ctx_e     rf_ctx_sel_i,
  input  reg_addr_t    rf_raddr_a_i,
  output reg_data_t    rf_rdata_a_o,
  input  reg_addr_t    rf_raddr_b_i,
  output reg_data_t    rf_rdata_b_o,
  input  reg_addr_t    rf_waddr_i,
  input  reg_data_t    rf_wdata_i,
  input  logic         rf_we_i,

  // Cache tag RAMs
  input  ic_way_mask_t ic_tag_req_i,
  input  logic         ic_tag_write_i,
  input  ic_index_t    ic_tag_addr_i,
  input  ic_tag_t      ic_tag_wdata_i,
  output ic_tag_t      ic_tag_rdata_o [IcNumWays],

  // Cache data RAMs
  input  ic_way_mask_t ic_data_req_i,
  input  logic         ic_data_write_i,
  input  ic_index_t    ic_data_addr_i,
  input  ic_line_t     ic_data_wdata_i,
  output ic_line_t     ic_data_rdata_o [IcNumWays]
);

  logic clk_core;

  ////////////////////////////////////////////////////////////////////////////
  // Sleep control and clock gate
  ////////////////////////////////////////////////////////////////////////////

  core_sleep_ctrl u_sleep_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .test_en_i    (test_en_i),
    .core_busy_i  (core_busy_i),
    .irq_pending_i(irq_pending_i),
    .irq_nm_i     (irq_nm_i),
    .debug_req_i  (debug_req_i),
    .clk_core_o   (clk_core),
    .core_sleep_o (core_sleep_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Register file contexts
  ////////////////////////////////////////////////////////////////////////////

  register_file_ctx u_register_file_ctx (
    .clk_i    (clk_core),
    .rst_ni   (rst_ni),
    .ctx_sel_i(rf_ctx_sel_i),
    .raddr_a_i(rf_raddr_a_i),
    .rdata_a_o(rf_rdata_a_o),
    .raddr_b_i(rf_raddr_b_i),
    .rdata_b_o(rf_rdata_b_o),
    .waddr_i  (rf_waddr_i),
    .wdata_i  (rf_wdata_i),
    .we_i     (rf_we_i)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Cache RAMs
  ////////////////////////////////////////////////////////////////////////////

  // Ungated clock, so the cache can fill while the core sleeps
  for (genvar way = 0; way < IcNumWays; way++) begin : gen_ways
    ic_ram_1p #(
      .payload_t(ic_tag_t)
    ) u_tag_ram (
      .clk_i  (clk_i),
      .req_i  (ic_tag_req_i[way]),
      .write_i(ic_tag_write_i),
      .addr_i (ic_tag_addr_i),
      .wdata_i(ic_tag_wdata_i),
      .rdata_o(ic_tag_rdata_o[way])
    );

    ic_ram_1p #(
      .payload_t(ic_line_t)
    ) u_data_ram (
      .clk_i  (clk_i),
      .req_i  (ic_data_req_i[way]),
      .write_i(ic_data_write_i),
      .addr_i (ic_data_addr_i),
      .wdata_i(ic_data_wdata_i),
      .rdata_o(ic_data_rdata_o[way])
    );
  end

endmodule

//--- testbench/tb_core_storage.sv
// Testbench for the core storage top level
// Directed tests of sleep control, clock gating, register file contexts
// and the instruction cache RAMs, checked against testbench models

`timescale 1ns/100ps

module tb_core_storage import core_pkg::*; ();

  localparam int unsigned ClkHalfPeriod = 2;
  localparam int unsigned DriveDelay    = 1;
  localparam int unsigned SleepTimeout  = 8;
  localparam int unsigned RandomOps     = 200;

  logic         clk_i;
  logic         rst_ni;
  logic         test_en_i;
  logic         core_busy_i;
  logic         irq_pending_i;
  logic         irq_nm_i;
  logic         debug_req_i;
  logic         core_sleep_o;
  reg_ctx_e     rf_ctx_sel_i;
  reg_addr_t    rf_raddr_a_i;
  reg_data_t    rf_rdata_a_o;
  reg_addr_t    rf_raddr_b_i;
  reg_data_t    rf_rdata_b_o;
  reg_addr_t    rf_waddr_i;
  reg_data_t    rf_wdata_i;
  logic         rf_we_i;
  ic_way_mask_t ic_tag_req_i;
  logic         ic_tag_write_i;
  ic_index_t    ic_tag_addr_i;
  ic_tag_t      ic_tag_wdata_i;
  ic_tag_t      ic_tag_rdata_o [IcNumWays];
  ic_way_mask_t ic_data_req_i;
  logic         ic_data_write_i;
  ic_index_t    ic_data_addr_i;
  ic_line_t     ic_data_wdata_i;
  ic_line_t     ic_data_rdata_o [IcNumWays];

  int unsigned errors;
  int unsigned timeouts;
  int unsigned checks;
  int          seed;

  // Reference models
  reg_data_t model_rf   [NrRegCtx][NumRegs];
  ic_tag_t   tag_mem    [IcNumWays][IcNumLines];
  ic_line_t  line_mem   [IcNumWays][IcNumLines];
  ic_tag_t   tag_rdata  [IcNumWays];
  ic_line_t  line_rdata [IcNumWays];

  core_storage_top i_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .test_en_i      (test_en_i),
    .core_busy_i    (core_busy_i),
    .irq_pending_i  (irq_pending_i),
    .irq_nm_i       (irq_nm_i),
    .debug_req_i    (debug_req_i),
    .core_sleep_o   (core_sleep_o),
    .rf_ctx_sel_i   (rf_ctx_sel_i),
    .rf_raddr_a_i   (rf_raddr_a_i),
    .rf_rdata_a_o   (rf_rdata_a_o),
    .rf_raddr_b_i   (rf_raddr_b_i),
    .rf_rdata_b_o   (rf_rdata_b_o),
    .rf_waddr_i     (rf_waddr_i),
    .rf_wdata_i     (rf_wdata_i),
    .rf_we_i        (rf_we_i),
    .ic_tag_req_i   (ic_tag_req_i),
    .ic_tag_write_i (ic_tag_write_i),
    .ic_tag_addr_i  (ic_tag_addr_i),
    .ic_tag_wdata_i (ic_tag_wdata_i),
    .ic_tag_rdata_o (ic_tag_rdata_o),
    .ic_data_req_i  (ic_data_req_i),
    .ic_data_write_i(ic_data_write_i),
    .ic_data_addr_i (ic_data_addr_i),
    .ic_data_wdata_i(ic_data_wdata_i),
    .ic_data_rdata_o(ic_data_rdata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(ClkHalfPeriod) clk_i = ~clk_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Next drive point, shortly after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #(DriveDelay);
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic set_wake(input int src, input logic val);
    case (src)
      0:       irq_pending_i = val;
      1:       irq_nm_i      = val;
      default: debug_req_i   = val;
    endcase
  endtask

  task automatic wait_sleep(input logic expected, output int cycles);
    cycles = 0;
    while (core_sleep_o !== expected && cycles < SleepTimeout) begin
      next_cycle();
      cycles++;
    end
    if (core_sleep_o !== expected) begin
      timeouts++;
      $display("timeout: core_sleep_o did not reach %b in %0d cycles", expected, SleepTimeout);
    end
  endtask

  // Write strobe with no model update
  task automatic strobe_write(input reg_ctx_e ctx, input reg_addr_t addr,
                              input reg_data_t data);
    rf_ctx_sel_i = ctx;
    rf_waddr_i   = addr;
    rf_wdata_i   = data;
    rf_we_i      = 1'b1;
    next_cycle();
    rf_we_i      = 1'b0;
  endtask

  task automatic write_reg(input reg_ctx_e ctx, input reg_addr_t addr, input reg_data_t data);
    strobe_write(ctx, addr, data);
    if (addr != '0) begin
      model_rf[ctx][addr] = data;
    end
  endtask

  task automatic check_reads(input reg_ctx_e ctx, input reg_addr_t addr_a,
                             input reg_addr_t addr_b);
    rf_ctx_sel_i = ctx;
    rf_raddr_a_i = addr_a;
    rf_raddr_b_i = addr_b;
    #(DriveDelay);
    check_value($sformatf("ctx %0d x%0d port A", ctx, addr_a), 64'(rf_rdata_a_o),
                64'(model_rf[ctx][addr_a]));
    check_value($sformatf("ctx %0d x%0d port B", ctx, addr_b), 64'(rf_rdata_b_o),
                64'(model_rf[ctx][addr_b]));
    next_cycle();
  endtask

  // One request on the tag and data RAMs of the masked ways
  task automatic ram_access(input ic_way_mask_t mask, input logic write, input ic_index_t idx);
    ic_tag_t  tag;
    ic_line_t line;
    tag  = ic_tag_t'($random(seed));
    line = {$random(seed), $random(seed)};
    ic_tag_req_i    = mask;
    ic_data_req_i   = mask;
    ic_tag_write_i  = write;
    ic_data_write_i = write;
    ic_tag_addr_i   = idx;
    ic_data_addr_i  = idx;
    ic_tag_wdata_i  = tag;
    ic_data_wdata_i = line;
    next_cycle();
    ic_tag_req_i    = '0;
    ic_data_req_i   = '0;
    for (int w = 0; w < IcNumWays; w++) begin
      if (mask[w] && write) begin
        tag_mem[w][idx]  = tag;
        line_mem[w][idx] = line;
      end else if (mask[w]) begin
        tag_rdata[w]  = tag_mem[w][idx];
        line_rdata[w] = line_mem[w][idx];
      end
    end
  endtask

  task automatic check_ram_rdata(input string what);
    for (int w = 0; w < IcNumWays; w++) begin
      check_value($sformatf("%s way %0d tag", what, w), 64'(ic_tag_rdata_o[w]),
                  64'(tag_rdata[w]));
      check_value($sformatf("%s way %0d line", what, w), ic_data_rdata_o[w], line_rdata[w]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_sleep_wake();
    int cycles;
    check_value("core_sleep_o after reset", 64'(core_sleep_o), 64'd1);
    for (int src = 0; src < 3; src++) begin
      set_wake(src, 1'b1);
      #(DriveDelay);
      check_value($sformatf("core_sleep_o with wake source %0d", src), 64'(core_sleep_o), 64'd0);
      next_cycle();
      set_wake(src, 1'b0);
      #(DriveDelay);
      check_value("core_sleep_o after wake source drops", 64'(core_sleep_o), 64'd1);
      next_cycle();
    end
    core_busy_i = 1'b1;
    wait_sleep(1'b0, cycles);
    check_value("cycles from busy rise to awake", 64'(cycles), 64'd1);
    core_busy_i = 1'b0;
    wait_sleep(1'b1, cycles);
    check_value("cycles from busy fall to sleep", 64'(cycles), 64'd1);
  endtask

  task automatic test_rf_basic();
    core_busy_i = 1'b1;
    next_cycle();
    for (int i = 1; i <= 5; i++) begin
      write_reg(RegCtxMain, reg_addr_t'(i), reg_data_t'(32'ha500_0000 + i));
      check_reads(RegCtxMain, reg_addr_t'(i), reg_addr_t'(i));
    end
    write_reg(RegCtxMain, '0, 32'hdead_beef);
    check_reads(RegCtxMain, '0, '0);
    check_reads(RegCtxMain, 5'd2, 5'd4);
  endtask

  task automatic test_ctx();
    write_reg(RegCtxMain, 5'd10, 32'h1111_aaaa);
    write_reg(RegCtxAlt, 5'd10, 32'h2222_bbbb);
    check_reads(RegCtxMain, 5'd10, 5'd20);
    check_reads(RegCtxAlt, 5'd10, 5'd20);
    // Main context wrote x1 and x5 earlier, the alternate one did not
    check_reads(RegCtxAlt, 5'd1, 5'd5);
  endtask

  task automatic test_gating();
    write_reg(RegCtxMain, 5'd7, 32'h0bad_f00d);
    core_busy_i = 1'b0;
    next_cycle();
    strobe_write(RegCtxMain, 5'd7, 32'h5555_1234);
    check_reads(RegCtxMain, 5'd7, 5'd7);
    test_en_i = 1'b1;
    write_reg(RegCtxMain, 5'd7, 32'h5555_1234);
    check_reads(RegCtxMain, 5'd7, 5'd7);
    test_en_i   = 1'b0;
    core_busy_i = 1'b1;
    next_cycle();
  endtask

  task automatic test_cache();
    ram_access(2'b01, 1'b1, 6'h2a);
    ram_access(2'b10, 1'b1, 6'h2a);
    ram_access(2'b01, 1'b1, 6'h15);
    ram_access(2'b11, 1'b0, 6'h2a);
    check_ram_rdata("read both ways");
    ram_access(2'b01, 1'b0, 6'h15);
    check_ram_rdata("read way 0 only");
    ram_access(2'b11, 1'b1, 6'h2a);
    check_ram_rdata("after write");
    ram_access(2'b11, 1'b0, 6'h2a);
    check_ram_rdata("read back new data");
  endtask

  task automatic test_random();
    logic [31:0] rnd;
    reg_ctx_e    wctx;
    reg_ctx_e    rctx;
    for (int i = 0; i < RandomOps; i++) begin
      rnd  = $random(seed);
      wctx = reg_ctx_e'(rnd[0]);
      rctx = reg_ctx_e'(rnd[11]);
      write_reg(wctx, rnd[5:1], $random(seed));
      check_reads(rctx, rnd[10:6], rnd[5:1]);
    end
  endtask

  initial begin
    seed     = 32'h44e1;
    errors   = 0;
    timeouts = 0;
    checks   = 0;
    for (int c = 0; c < NrRegCtx; c++) begin
      for (int r = 0; r < NumRegs; r++) begin
        model_rf[c][r] = '0;
      end
    end
    rst_ni          = 1'b0;
    test_en_i       = 1'b0;
    core_busy_i     = 1'b0;
    irq_pending_i   = 1'b0;
    irq_nm_i        = 1'b0;
    debug_req_i     = 1'b0;
    rf_ctx_sel_i    = RegCtxMain;
    rf_raddr_a_i    = '0;
    rf_raddr_b_i    = '0;
    rf_waddr_i      = '0;
    rf_wdata_i      = '0;
    rf_we_i         = 1'b0;
    ic_tag_req_i    = '0;
    ic_tag_write_i  = 1'b0;
    ic_tag_addr_i   = '0;
    ic_tag_wdata_i  = '0;
    ic_data_req_i   = '0;
    ic_data_write_i = 1'b0;
    ic_data_addr_i  = '0;
    ic_data_wdata_i = '0;
    repeat (2) @(posedge clk_i);
    #(DriveDelay);
    rst_ni = 1'b1;

    test_sleep_wake();
    test_rf_basic();
    test_ctx();
    test_gating();
    test_cache();
    test_random();

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- list.f
verilog/core_pkg.sv
verilog/core_sleep_ctrl.sv
verilog/register_file_ff.sv
verilog/register_file_ctx.sv
verilog/ic_ram_1p.sv
verilog/core_storage_top.sv
testbench/tb_core_storage.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       := tb_core_storage
RTL_TOP   := core_storage_top
FILELIST  := list.f
BUILD_DIR := obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
